// File: source/sysctrl_consts.svh
`ifndef SYSCTRL_CONSTS_SVH
`define SYSCTRL_CONSTS_SVH

// upper address bits that select the block.
`define SYSCTRL_BASE_PAGE 24'h2F0000

// clock output enables and destinations.
`define SYSCTRL_OSC_ENA   8'h00
`define SYSCTRL_OSC_OUT   8'h04
`define SYSCTRL_XTAL_OUT  8'h08
`define SYSCTRL_PLL_OUT   8'h0C

// trap flag destination.
`define SYSCTRL_TRAP_OUT  8'h10

// interrupt source selects.
`define SYSCTRL_IRQ7_SRC  8'h14
`define SYSCTRL_IRQ8_SRC  8'h18

// over-temperature enable, level and destination.
`define SYSCTRL_OT_ENA    8'h1C
`define SYSCTRL_OT_DATA   8'h20
`define SYSCTRL_OT_OUT    8'h24

// debug pads.
`define SYSCTRL_NUM_PADS  3

`endif

// File: source/sysctrl_bus_pkg.sv
package sysctrl_bus_pkg;

    // upper 24 bits of the word address pick the page.
    typedef logic [31:0] bus_addr_t;

    typedef logic [31:0] bus_data_t;

    // only byte select bit 0 is used.
    typedef logic [3:0] bus_strb_t;

    // single-cycle acknowledge handshake.
    typedef enum logic {
        IDLE = 1'b0,
        ACK  = 1'b1
    } bus_state_t;

endpackage

// File: source/sysctrl_cfg_pkg.sv
package sysctrl_cfg_pkg;

    // 0 is unrouted, 1 to 3 select pad 0 to pad 2.
    typedef logic [1:0] pad_dest_t;

    // index into the four interrupt candidate lines.
    typedef logic [1:0] irq_src_t;

endpackage

// File: source/sysctrl_cfg_if.sv
`timescale 1ns/1ns

interface sysctrl_cfg_if;
    import sysctrl_cfg_pkg::*;

    logic      rcosc_ena;
    pad_dest_t osc_dest;
    pad_dest_t xtal_dest;
    pad_dest_t pll_dest;
    pad_dest_t trap_dest;
    irq_src_t  irq7_src;
    irq_src_t  irq8_src;
    logic      ot_ena;
    pad_dest_t ot_dest;

    // synchronized and enabled over-temperature level.
    logic      ot_level;

    modport regs (
        output rcosc_ena, osc_dest, xtal_dest, pll_dest, trap_dest,
        output irq7_src, irq8_src, ot_ena, ot_dest,
        input  ot_level
    );

    modport router (
        input  rcosc_ena, osc_dest, xtal_dest, pll_dest, trap_dest,
        input  irq7_src, irq8_src, ot_ena, ot_dest,
        output ot_level
    );

endinterface

// File: source/sysctrl_regs.sv
`timescale 1ns/1ns

`include "sysctrl_consts.svh"

module sysctrl_regs (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        cyc_i,
    input  logic                        stb_i,
    input  logic                        we_i,
    input  sysctrl_bus_pkg::bus_strb_t  sel_i,
    input  sysctrl_bus_pkg::bus_addr_t  adr_i,
    input  sysctrl_bus_pkg::bus_data_t  dat_i,
    output sysctrl_bus_pkg::bus_data_t  dat_o,
    output logic                        ack_o,
    sysctrl_cfg_if.regs                 cfg
);
    import sysctrl_bus_pkg::*;

    bus_state_t state_q;
    bus_data_t  rdata_d;
    logic [7:0] offset;
    logic       req;
    logic       accept;
    logic       wr_en;

    assign offset = adr_i[7:0];
    assign req    = cyc_i && stb_i && (adr_i[31:8] == `SYSCTRL_BASE_PAGE);

    // only an idle block takes a new request.
    assign accept = (state_q == IDLE) && req;
    assign wr_en  = accept && we_i && sel_i[0];
    assign ack_o  = (state_q == ACK);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req) begin
                        state_q <= ACK;
                    end
                end
                ACK: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // zero-extended readback of the addressed field.
    always_comb begin
        rdata_d = '0;
        case (offset)
            `SYSCTRL_OSC_ENA:  rdata_d[0]   = cfg.rcosc_ena;
            `SYSCTRL_OSC_OUT:  rdata_d[1:0] = cfg.osc_dest;
            `SYSCTRL_XTAL_OUT: rdata_d[1:0] = cfg.xtal_dest;
            `SYSCTRL_PLL_OUT:  rdata_d[1:0] = cfg.pll_dest;
            `SYSCTRL_TRAP_OUT: rdata_d[1:0] = cfg.trap_dest;
            `SYSCTRL_IRQ7_SRC: rdata_d[1:0] = cfg.irq7_src;
            `SYSCTRL_IRQ8_SRC: rdata_d[1:0] = cfg.irq8_src;
            `SYSCTRL_OT_ENA:   rdata_d[0]   = cfg.ot_ena;
            `SYSCTRL_OT_DATA:  rdata_d[0]   = cfg.ot_level;
            `SYSCTRL_OT_OUT:   rdata_d[1:0] = cfg.ot_dest;
            default:           rdata_d      = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dat_o <= rdata_d;
        end
    end

    // OT_DATA and unmapped offsets ignore writes.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cfg.rcosc_ena <= 1'b0;
            cfg.osc_dest  <= '0;
            cfg.xtal_dest <= '0;
            cfg.pll_dest  <= '0;
            cfg.trap_dest <= '0;
            cfg.irq7_src  <= '0;
            cfg.irq8_src  <= '0;
            cfg.ot_ena    <= 1'b0;
            cfg.ot_dest   <= '0;
        end else if (wr_en) begin
            case (offset)
                `SYSCTRL_OSC_ENA:  cfg.rcosc_ena <= dat_i[0];
                `SYSCTRL_OSC_OUT:  cfg.osc_dest  <= dat_i[1:0];
                `SYSCTRL_XTAL_OUT: cfg.xtal_dest <= dat_i[1:0];
                `SYSCTRL_PLL_OUT:  cfg.pll_dest  <= dat_i[1:0];
                `SYSCTRL_TRAP_OUT: cfg.trap_dest <= dat_i[1:0];
                `SYSCTRL_IRQ7_SRC: cfg.irq7_src  <= dat_i[1:0];
                `SYSCTRL_IRQ8_SRC: cfg.irq8_src  <= dat_i[1:0];
                `SYSCTRL_OT_ENA:   cfg.ot_ena    <= dat_i[0];
                `SYSCTRL_OT_OUT:   cfg.ot_dest   <= dat_i[1:0];
                default: begin
                end
            endcase
        end
    end

endmodule

// File: source/sysctrl_router.sv
`timescale 1ns/1ns

`include "sysctrl_consts.svh"

module sysctrl_router (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         rcosc_clk_i,
    input  logic                         xtal_clk_i,
    input  logic                         pll_clk_i,
    input  logic                         trap_i,
    input  logic                         overtemp_i,
    input  logic [3:0]                   irq_line_i,
    output logic [`SYSCTRL_NUM_PADS-1:0] dbg_pad_o,
    output logic                         irq7_o,
    output logic                         irq8_o,
    sysctrl_cfg_if.router                cfg
);
    import sysctrl_cfg_pkg::*;

    logic [`SYSCTRL_NUM_PADS-1:0] osc_mask;
    logic [`SYSCTRL_NUM_PADS-1:0] xtal_mask;
    logic [`SYSCTRL_NUM_PADS-1:0] pll_mask;
    logic [`SYSCTRL_NUM_PADS-1:0] trap_mask;
    logic [`SYSCTRL_NUM_PADS-1:0] ot_mask;
    logic                         rcosc_gated;
    logic                         ot_meta_q;
    logic                         ot_sync_q;

    // one-hot pad mask where code 0 routes nowhere.
    function automatic logic [`SYSCTRL_NUM_PADS-1:0] dest_mask(input pad_dest_t dest);
        logic [`SYSCTRL_NUM_PADS-1:0] mask;
        mask = '0;
        for (int i = 0; i < `SYSCTRL_NUM_PADS; i++) begin
            mask[i] = (dest == pad_dest_t'(i + 1));
        end
        return mask;
    endfunction

    assign osc_mask  = dest_mask(cfg.osc_dest);
    assign xtal_mask = dest_mask(cfg.xtal_dest);
    assign pll_mask  = dest_mask(cfg.pll_dest);
    assign trap_mask = dest_mask(cfg.trap_dest);
    assign ot_mask   = dest_mask(cfg.ot_dest);

    assign rcosc_gated = rcosc_clk_i & cfg.rcosc_ena;

    // plain gating without glitch-free switching.
    assign dbg_pad_o = (osc_mask  & {`SYSCTRL_NUM_PADS{rcosc_gated}})
                     | (xtal_mask & {`SYSCTRL_NUM_PADS{xtal_clk_i}})
                     | (pll_mask  & {`SYSCTRL_NUM_PADS{pll_clk_i}})
                     | (trap_mask & {`SYSCTRL_NUM_PADS{trap_i}})
                     | (ot_mask   & {`SYSCTRL_NUM_PADS{cfg.ot_level}});

    assign irq7_o = irq_line_i[cfg.irq7_src];
    assign irq8_o = irq_line_i[cfg.irq8_src];

    // two-flop synchronizer for the async over-temperature input.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ot_meta_q <= 1'b0;
            ot_sync_q <= 1'b0;
        end else begin
            ot_meta_q <= overtemp_i;
            ot_sync_q <= ot_meta_q;
        end
    end

    assign cfg.ot_level = ot_sync_q & cfg.ot_ena;

endmodule

// File: source/sysctrl_top.sv
`timescale 1ns/1ns

`include "sysctrl_consts.svh"

module sysctrl_top (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         cyc_i,
    input  logic                         stb_i,
    input  logic                         we_i,
    input  sysctrl_bus_pkg::bus_strb_t   sel_i,
    input  sysctrl_bus_pkg::bus_addr_t   adr_i,
    input  sysctrl_bus_pkg::bus_data_t   dat_i,
    output sysctrl_bus_pkg::bus_data_t   dat_o,
    output logic                         ack_o,
    input  logic                         rcosc_clk_i,
    input  logic                         xtal_clk_i,
    input  logic                         pll_clk_i,
    input  logic                         trap_i,
    input  logic [3:0]                   irq_line_i,
    input  logic                         overtemp_i,
    output logic [`SYSCTRL_NUM_PADS-1:0] dbg_pad_o,
    output logic                         irq7_o,
    output logic                         irq8_o,
    output logic                         rcosc_ena_o
);

    sysctrl_cfg_if cfg_bus ();

    sysctrl_regs u_regs (
        .clk    (clk),
        .resetn (resetn),
        .cyc_i  (cyc_i),
        .stb_i  (stb_i),
        .we_i   (we_i),
        .sel_i  (sel_i),
        .adr_i  (adr_i),
        .dat_i  (dat_i),
        .dat_o  (dat_o),
        .ack_o  (ack_o),
        .cfg    (cfg_bus.regs)
    );

    sysctrl_router u_router (
        .clk         (clk),
        .resetn      (resetn),
        .rcosc_clk_i (rcosc_clk_i),
        .xtal_clk_i  (xtal_clk_i),
        .pll_clk_i   (pll_clk_i),
        .trap_i      (trap_i),
        .overtemp_i  (overtemp_i),
        .irq_line_i  (irq_line_i),
        .dbg_pad_o   (dbg_pad_o),
        .irq7_o      (irq7_o),
        .irq8_o      (irq8_o),
        .cfg         (cfg_bus.router)
    );

    // oscillator enable leaves the chip as well.
    assign rcosc_ena_o = cfg_bus.rcosc_ena;

endmodule

// File: tb/sysctrl_checker.sv
`timescale 1ns/1ns

module sysctrl_checker (
    input logic clk,
    input logic resetn,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_o
);

    // single-cycle acknowledge.
    assert property (@(posedge clk) disable iff (!resetn) ack_o |=> !ack_o)
        else $error("ack_o held high for two cycles");

    // nothing pending right after reset.
    assert property (@(posedge clk) !resetn |=> !ack_o)
        else $error("ack_o high in the cycle after reset");

    // an acknowledge needs a request on the previous edge.
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(ack_o) |-> $past(cyc_i && stb_i))
        else $error("ack_o rose without a request");

endmodule

bind sysctrl_regs sysctrl_checker u_checker (
    .clk    (clk),
    .resetn (resetn),
    .cyc_i  (cyc_i),
    .stb_i  (stb_i),
    .ack_o  (ack_o)
);

// File: tb/sysctrl_tb.sv
`timescale 1ns/1ns

`include "sysctrl_consts.svh"

module sysctrl_tb;
    import sysctrl_bus_pkg::*;
    import sysctrl_cfg_pkg::*;

    localparam int CYCLE_LIMIT = 2000;

    logic clk, resetn, cyc, stb, we;
    bus_strb_t sel;
    bus_addr_t adr;
    bus_data_t dat_w, dat_r;
    logic ack, rcosc_clk, xtal_clk, pll_clk, trap, overtemp;
    logic [3:0] irq_line;
    logic [`SYSCTRL_NUM_PADS-1:0] pads;
    logic irq7, irq8, rcosc_ena;

    int errors = 0;
    int checks = 0;
    int test_errors;
    int cycles = 0;
    logic [15:0] lfsr_q = 16'd39;

    // register mirror.
    logic m_osc_ena, m_ot_ena;
    pad_dest_t m_osc, m_xtal, m_pll, m_trap, m_ot;
    irq_src_t m_irq7, m_irq8;

    sysctrl_top u_dut (
        .clk(clk), .resetn(resetn), .cyc_i(cyc), .stb_i(stb), .we_i(we),
        .sel_i(sel), .adr_i(adr), .dat_i(dat_w), .dat_o(dat_r), .ack_o(ack),
        .rcosc_clk_i(rcosc_clk), .xtal_clk_i(xtal_clk), .pll_clk_i(pll_clk),
        .trap_i(trap), .irq_line_i(irq_line), .overtemp_i(overtemp),
        .dbg_pad_o(pads), .irq7_o(irq7), .irq8_o(irq8), .rcosc_ena_o(rcosc_ena)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps for x^16 + x^14 + x^13 + x^11.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [2:0] pad_of(input pad_dest_t d, input logic src);
        logic [2:0] m;
        m = '0;
        if (d != 2'd0) begin
            m[d - 2'd1] = src;
        end
        return m;
    endfunction

    function automatic logic [2:0] ref_pads(input logic rc, input logic xt, input logic pl,
                                            input logic tr, input logic ot);
        return pad_of(m_osc, rc & m_osc_ena) | pad_of(m_xtal, xt) | pad_of(m_pll, pl)
             | pad_of(m_trap, tr) | pad_of(m_ot, ot & m_ot_ena);
    endfunction

    function automatic bus_data_t ref_read(input logic [7:0] off, input logic ot);
        case (off)
            `SYSCTRL_OSC_ENA:  return {31'd0, m_osc_ena};
            `SYSCTRL_OSC_OUT:  return {30'd0, m_osc};
            `SYSCTRL_XTAL_OUT: return {30'd0, m_xtal};
            `SYSCTRL_PLL_OUT:  return {30'd0, m_pll};
            `SYSCTRL_TRAP_OUT: return {30'd0, m_trap};
            `SYSCTRL_IRQ7_SRC: return {30'd0, m_irq7};
            `SYSCTRL_IRQ8_SRC: return {30'd0, m_irq8};
            `SYSCTRL_OT_ENA:   return {31'd0, m_ot_ena};
            `SYSCTRL_OT_DATA:  return {31'd0, ot & m_ot_ena};
            `SYSCTRL_OT_OUT:   return {30'd0, m_ot};
            default:           return '0;
        endcase
    endfunction

    task automatic mirror_write(input logic [7:0] off, input bus_data_t d);
        case (off)
            `SYSCTRL_OSC_ENA:  m_osc_ena = d[0];
            `SYSCTRL_OSC_OUT:  m_osc = d[1:0];
            `SYSCTRL_XTAL_OUT: m_xtal = d[1:0];
            `SYSCTRL_PLL_OUT:  m_pll = d[1:0];
            `SYSCTRL_TRAP_OUT: m_trap = d[1:0];
            `SYSCTRL_IRQ7_SRC: m_irq7 = d[1:0];
            `SYSCTRL_IRQ8_SRC: m_irq8 = d[1:0];
            `SYSCTRL_OT_ENA:   m_ot_ena = d[0];
            `SYSCTRL_OT_OUT:   m_ot = d[1:0];
            default: begin
            end
        endcase
    endtask

    task automatic note_fail();
        errors++;
        test_errors++;
    endtask

    task automatic check_data(input bus_data_t got, input bus_data_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, msg, got, exp);
            note_fail();
        end
    endtask

    task automatic check_pads(input logic [2:0] got, input logic [2:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %b expected %b", $time, msg, got, exp);
            note_fail();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %b expected %b", $time, msg, got, exp);
            note_fail();
        end
    endtask

    task automatic bus_cycle(input logic wr, input logic [7:0] off, input bus_data_t d,
                             input logic sel0, output bus_data_t rd);
        @(posedge clk);
        #5;
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        sel = {3'b000, sel0};
        adr = {`SYSCTRL_BASE_PAGE, off};
        dat_w = d;
        do begin
            @(posedge clk);
            #5;
        end while (!ack);
        rd = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] off, input bus_data_t d, input logic sel0);
        bus_data_t unused;
        bus_cycle(1'b1, off, d, sel0, unused);
        if (sel0) begin
            mirror_write(off, d);
        end
    endtask

    task automatic wb_read(input logic [7:0] off, output bus_data_t rd);
        bus_cycle(1'b0, off, '0, 1'b0, rd);
    endtask

    task automatic read_check(input logic [7:0] off, input logic ot);
        bus_data_t rd;
        wb_read(off, rd);
        check_data(rd, ref_read(off, ot), $sformatf("readback of offset %h", off));
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [7:0] offs [9];
        logic [2:0] ot_pad;
        bus_data_t v;
        offs = '{`SYSCTRL_OSC_ENA, `SYSCTRL_OSC_OUT, `SYSCTRL_XTAL_OUT, `SYSCTRL_PLL_OUT,
                 `SYSCTRL_TRAP_OUT, `SYSCTRL_IRQ7_SRC, `SYSCTRL_IRQ8_SRC, `SYSCTRL_OT_ENA,
                 `SYSCTRL_OT_OUT};
        resetn = 1'b0;
        {cyc, stb, we} = 3'b000;
        sel = '0;
        adr = '0;
        dat_w = '0;
        {rcosc_clk, xtal_clk, pll_clk, trap, overtemp} = 5'b00000;
        irq_line = 4'b0101;
        {m_osc_ena, m_ot_ena} = 2'b00;
        {m_osc, m_xtal, m_pll, m_trap, m_ot, m_irq7, m_irq8} = '0;
        test_errors = 0;
        repeat (4) @(posedge clk);
        #5;
        resetn = 1'b1;

        // 1. reset state.
        #10;
        check_pads(pads, 3'b000, "pads after reset");
        check_bit(rcosc_ena, 1'b0, "rcosc_ena_o after reset");
        check_bit(irq7, irq_line[0], "irq7 after reset");
        check_bit(irq8, irq_line[0], "irq8 after reset");
        foreach (offs[i]) read_check(offs[i], 1'b0);
        read_check(`SYSCTRL_OT_DATA, 1'b0);
        end_test("reset");

        // 2. write and readback.
        foreach (offs[i]) begin
            wb_write(offs[i], lfsr_bits(32), 1'b1);
            read_check(offs[i], 1'b0);
            wb_write(offs[i], lfsr_bits(32), 1'b0);
            read_check(offs[i], 1'b0);
        end
        read_check(8'h28, 1'b0);
        read_check(8'h80, 1'b0);
        read_check(8'hFC, 1'b0);
        end_test("register");

        // 3. pad routing with static levels and over-temperature off.
        wb_write(`SYSCTRL_OT_ENA, '0, 1'b1);
        for (int n = 0; n < 12; n++) begin
            wb_write(`SYSCTRL_OSC_ENA, lfsr_bits(1), 1'b1);
            wb_write(`SYSCTRL_OSC_OUT, lfsr_bits(2), 1'b1);
            wb_write(`SYSCTRL_XTAL_OUT, lfsr_bits(2), 1'b1);
            wb_write(`SYSCTRL_PLL_OUT, lfsr_bits(2), 1'b1);
            wb_write(`SYSCTRL_TRAP_OUT, lfsr_bits(2), 1'b1);
            v = lfsr_bits(4);
            {rcosc_clk, xtal_clk, pll_clk, trap} = v[3:0];
            #10;
            check_pads(pads, ref_pads(rcosc_clk, xtal_clk, pll_clk, trap, 1'b0), "pad routing");
            check_bit(rcosc_ena, m_osc_ena, "rcosc_ena_o");
        end
        end_test("pads");

        // 4. interrupt selection.
        for (int s = 0; s < 4; s++) begin
            wb_write(`SYSCTRL_IRQ7_SRC, s, 1'b1);
            wb_write(`SYSCTRL_IRQ8_SRC, 3 - s, 1'b1);
            repeat (4) begin
                @(posedge clk);
                #5;
                v = lfsr_bits(4);
                irq_line = v[3:0];
                #10;
                check_bit(irq7, irq_line[m_irq7], "irq7 select");
                check_bit(irq8, irq_line[m_irq8], "irq8 select");
            end
        end
        end_test("irq");

        // 5. over-temperature path.
        foreach (offs[i]) if (i >= 1 && i <= 4) wb_write(offs[i], '0, 1'b1);
        wb_write(`SYSCTRL_OT_ENA, lfsr_bits(1), 1'b1);
        wb_write(`SYSCTRL_OT_OUT, 32'd1 + (lfsr_bits(2) % 3), 1'b1);
        for (int n = 0; n < 8; n++) begin
            if (n == 4) begin
                wb_write(`SYSCTRL_OT_ENA, {31'd0, !m_ot_ena}, 1'b1);
            end
            v = lfsr_bits(1);
            overtemp = v[0];
            repeat (3) @(posedge clk);
            #5;
            read_check(`SYSCTRL_OT_DATA, overtemp);
            ot_pad = ref_pads(rcosc_clk, xtal_clk, pll_clk, trap, overtemp);
            check_pads(pads, ot_pad, "over-temperature pad");
        end
        end_test("overtemp");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+source
source/sysctrl_bus_pkg.sv
source/sysctrl_cfg_pkg.sv
source/sysctrl_cfg_if.sv
source/sysctrl_regs.sv
source/sysctrl_router.sv
source/sysctrl_top.sv
tb/sysctrl_checker.sv
tb/sysctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator and run; pass only if the pass line shows up.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module sysctrl_tb -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
